/* hdl/usiPkg.sv */
//------------------------------
// Shared definitions for the board peripheral subsystem
// Register bus widths, block map, register maps and
// the bus controller state encoding
// Referenced by scoped names from every design file
//------------------------------
`default_nettype none

package usiPkg;

	//------------------------------
	// Bus widths
	//------------------------------
	localparam int lpDataWidth   = 32;
	localparam int lpAdrsWidth   = 8;
	localparam int lpRegIdxWidth = 4;
	// Upper address bits select the block
	localparam int lpBlkWidth    = lpAdrsWidth - lpRegIdxWidth;
	localparam int lpGpioWidth   = 6;

	// Register data word
	typedef logic [lpDataWidth-1:0]   usiData_t;
	// Wishbone word address, block field on top
	typedef logic [lpAdrsWidth-1:0]   usiAdrs_t;
	// Register index inside one block
	typedef logic [lpRegIdxWidth-1:0] usiRegIdx_t;
	// One bit per GPIO pin
	typedef logic [lpGpioWidth-1:0]   gpio_t;

	//------------------------------
	// Block map
	//------------------------------
	// Remaining block numbers are unmapped
	localparam logic [lpBlkWidth-1:0] lpGpioBlock  = 4'd0;
	localparam logic [lpBlkWidth-1:0] lpTimerBlock = 4'd1;

	// GPIO registers
	localparam usiRegIdx_t lpGpioOutReg = 4'd0;
	localparam usiRegIdx_t lpGpioDirReg = 4'd1;
	localparam usiRegIdx_t lpGpioAltReg = 4'd2;
	// Input readback, read only
	localparam usiRegIdx_t lpGpioInReg  = 4'd3;

	// Timer registers
	localparam usiRegIdx_t lpTimerCtrlReg  = 4'd0;
	localparam usiRegIdx_t lpTimerCountReg = 4'd1;
	localparam usiRegIdx_t lpTimerCmpReg   = 4'd2;
	localparam usiRegIdx_t lpTimerStatReg  = 4'd3;

	// Bus controller FSM states
	typedef enum logic [1:0]
	{
		busIdle,
		busAccess,
		busAck
	} busState_t;

endpackage

`default_nettype wire

/* hdl/usiBusIf.sv */
//------------------------------
// Register access channel between the bus controller
// and one peripheral block
// One instance per block, ctrl side on the controller
//------------------------------
`timescale 1ns/1ps
`default_nettype none

interface usiBusIf;

	// One cycle write strobe, this block only
	logic               wrEn;
	// Register index and write data, shared fan-out
	usiPkg::usiRegIdx_t regIdx;
	usiPkg::usiData_t   wrData;
	// Combinational readback of regIdx
	usiPkg::usiData_t   rdData;

	modport ctrl
	(
		output wrEn,
		output regIdx,
		output wrData,
		input  rdData
	);

	modport blk
	(
		input  wrEn,
		input  regIdx,
		input  wrData,
		output rdData
	);

endinterface

`default_nettype wire

/* hdl/usiBusCtrl.sv */
//------------------------------
// Wishbone classic slave in front of the register bus
// Fixed three cycle transfer: accept, access, ack
// Block field of the address picks the target block
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module usiBusCtrl
(
	input  logic              iMCLK,
	input  logic              qnARST,
	// Wishbone slave
	input  logic              wbCyc,
	input  logic              wbStb,
	input  logic              wbWe,
	input  usiPkg::usiAdrs_t  wbAdr,
	input  usiPkg::usiData_t  wbDatW,
	output usiPkg::usiData_t  wbDatR,
	output logic              wbAck,
	// Block channels
	usiBusIf.ctrl             gpioBus,
	usiBusIf.ctrl             timerBus
);

	usiPkg::busState_t busState;

	// Block field decode, done once here
	logic [usiPkg::lpBlkWidth-1:0] blkField;
	logic gpioHit;
	logic timerHit;
	logic accept;

	// Registered target of the current transfer
	logic gpioSel;
	logic timerSel;
	usiPkg::usiRegIdx_t regIdx;
	usiPkg::usiData_t   wrData;
	logic gpioWr;
	logic timerWr;

	assign blkField = wbAdr[usiPkg::lpAdrsWidth-1 -: usiPkg::lpBlkWidth];
	assign gpioHit  = (blkField == usiPkg::lpGpioBlock);
	assign timerHit = (blkField == usiPkg::lpTimerBlock);
	// New transfer only from idle
	assign accept   = wbCyc && wbStb && (busState == usiPkg::busIdle);

	//------------------------------
	// Transfer FSM and strobes
	//------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			busState <= usiPkg::busIdle;
			gpioWr   <= 1'b0;
			timerWr  <= 1'b0;
			wbDatR   <= '0;
		end
		else
		begin
			case (busState)
				usiPkg::busIdle:
				begin
					if (accept)
					begin
						// Strobe goes to the addressed block only
						gpioWr   <= wbWe && gpioHit;
						timerWr  <= wbWe && timerHit;
						busState <= usiPkg::busAccess;
					end
				end
				usiPkg::busAccess:
				begin
					gpioWr  <= 1'b0;
					timerWr <= 1'b0;
					// Unmapped block reads as zero
					if (gpioSel)
						wbDatR <= gpioBus.rdData;
					else if (timerSel)
						wbDatR <= timerBus.rdData;
					else
						wbDatR <= '0;
					busState <= usiPkg::busAck;
				end
				default:
				begin
					busState <= usiPkg::busIdle;
				end
			endcase
		end
	end

	// Address and data held for the access cycle
	always_ff @(posedge iMCLK)
	begin
		if (accept)
		begin
			gpioSel  <= gpioHit;
			timerSel <= timerHit;
			regIdx   <= wbAdr[usiPkg::lpRegIdxWidth-1:0];
			wrData   <= wbDatW;
		end
	end

	// Ack for exactly the one busAck cycle
	assign wbAck = (busState == usiPkg::busAck);

	// Fan-out to both blocks
	assign gpioBus.wrEn    = gpioWr;
	assign gpioBus.regIdx  = regIdx;
	assign gpioBus.wrData  = wrData;
	assign timerBus.wrEn   = timerWr;
	assign timerBus.regIdx = regIdx;
	assign timerBus.wrData = wrData;

endmodule

`default_nettype wire

/* hdl/gpioBlock.sv */
//------------------------------
// Six pin GPIO with output, direction and alternate
// function registers
// Alternate source per pin comes from the system timer
// Input readback through a two flop synchronizer
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioBlock
(
	input  logic          iMCLK,
	input  logic          qnARST,
	usiBusIf.blk          bus,
	// Pins
	input  usiPkg::gpio_t gpioIn,
	output usiPkg::gpio_t gpioOut,
	output usiPkg::gpio_t gpioOe,
	// Alternate sources
	input  logic          timerMatch,
	input  logic          timerBeat
);

	usiPkg::gpio_t outReg;
	usiPkg::gpio_t dirReg;
	usiPkg::gpio_t altReg;
	usiPkg::gpio_t syncMeta;
	usiPkg::gpio_t syncIn;
	usiPkg::gpio_t altSrc;

	//------------------------------
	// Register writes
	//------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			outReg <= '0;
			dirReg <= '0;
			altReg <= '0;
		end
		else if (bus.wrEn)
		begin
			case (bus.regIdx)
				usiPkg::lpGpioOutReg: outReg <= bus.wrData[usiPkg::lpGpioWidth-1:0];
				usiPkg::lpGpioDirReg: dirReg <= bus.wrData[usiPkg::lpGpioWidth-1:0];
				usiPkg::lpGpioAltReg: altReg <= bus.wrData[usiPkg::lpGpioWidth-1:0];
				// IN is read only
				default: ;
			endcase
		end
	end

	// Two flop input synchronizer
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			syncMeta <= '0;
			syncIn   <= '0;
		end
		else
		begin
			syncMeta <= gpioIn;
			syncIn   <= syncMeta;
		end
	end

	// Readback, upper bits zero
	always_comb
	begin
		bus.rdData = '0;
		case (bus.regIdx)
			usiPkg::lpGpioOutReg: bus.rdData[usiPkg::lpGpioWidth-1:0] = outReg;
			usiPkg::lpGpioDirReg: bus.rdData[usiPkg::lpGpioWidth-1:0] = dirReg;
			usiPkg::lpGpioAltReg: bus.rdData[usiPkg::lpGpioWidth-1:0] = altReg;
			usiPkg::lpGpioInReg:  bus.rdData[usiPkg::lpGpioWidth-1:0] = syncIn;
			default: ;
		endcase
	end

	//------------------------------
	// Pin mux
	//------------------------------
	// Heartbeat on even pins, match flag on odd pins
	always_comb
	begin
		for (int i = 0; i < usiPkg::lpGpioWidth; i++)
		begin
			altSrc[i] = (i % 2 == 0) ? timerBeat : timerMatch;
		end
	end

	assign gpioOut = (outReg & ~altReg) | (altSrc & altReg);
	// Oe set means the pin drives
	assign gpioOe  = dirReg;

endmodule

`default_nettype wire

/* hdl/sysTimerBlock.sv */
//------------------------------
// System timer, 32 bit up counter wrapping at COMPARE
// Each wrap sets a sticky match flag and toggles the
// heartbeat, both exported as GPIO alternate sources
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module sysTimerBlock
(
	input  logic iMCLK,
	input  logic qnARST,
	usiBusIf.blk bus,
	// Alternate sources for the GPIO block
	output logic timerMatch,
	output logic timerBeat
);

	logic             enable;
	usiPkg::usiData_t count;
	usiPkg::usiData_t cmpReg;
	logic             matchFlag;
	logic             heartbeat;
	logic             wrap;
	logic             clrMatch;

	// Wrap on the edge where count meets compare
	assign wrap = enable && (count == cmpReg);
	assign clrMatch = bus.wrEn && (bus.regIdx == usiPkg::lpTimerStatReg) && bus.wrData[0];

	//------------------------------
	// Control and compare
	//------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			enable <= 1'b0;
			cmpReg <= '0;
		end
		else if (bus.wrEn)
		begin
			if (bus.regIdx == usiPkg::lpTimerCtrlReg)
				enable <= bus.wrData[0];
			if (bus.regIdx == usiPkg::lpTimerCmpReg)
				cmpReg <= bus.wrData;
		end
	end

	// Counter, flag and heartbeat
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			count     <= '0;
			matchFlag <= 1'b0;
			heartbeat <= 1'b0;
		end
		else
		begin
			if (wrap)
			begin
				count     <= '0;
				heartbeat <= ~heartbeat;
			end
			else if (enable)
				count <= count + 1'b1;
			// Wrap wins over a clear in the same cycle
			if (wrap)
				matchFlag <= 1'b1;
			else if (clrMatch)
				matchFlag <= 1'b0;
		end
	end

	// Readback
	always_comb
	begin
		bus.rdData = '0;
		case (bus.regIdx)
			usiPkg::lpTimerCtrlReg:  bus.rdData[0] = enable;
			usiPkg::lpTimerCountReg: bus.rdData = count;
			usiPkg::lpTimerCmpReg:   bus.rdData = cmpReg;
			usiPkg::lpTimerStatReg:  bus.rdData[1:0] = {heartbeat, matchFlag};
			default: ;
		endcase
	end

	assign timerMatch = matchFlag;
	assign timerBeat  = heartbeat;

endmodule

`default_nettype wire

/* hdl/midiBoardTop.sv */
//------------------------------
// Board peripheral top level
// Wishbone classic slave in, GPIO pins out
// Bus controller feeding the GPIO and timer blocks
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module midiBoardTop
(
	input  logic             iMCLK,
	input  logic             qnARST,
	// Wishbone slave
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  usiPkg::usiAdrs_t wbAdr,
	input  usiPkg::usiData_t wbDatW,
	output usiPkg::usiData_t wbDatR,
	output logic             wbAck,
	// GPIO pins
	input  usiPkg::gpio_t    gpioIn,
	output usiPkg::gpio_t    gpioOut,
	output usiPkg::gpio_t    gpioOe
);

	// Timer signals for the GPIO alternate mux
	logic timerMatch;
	logic timerBeat;

	// One channel per block
	usiBusIf gpioBus();
	usiBusIf timerBus();

	usiBusCtrl usiBusCtrl
	(
		.iMCLK    (iMCLK),
		.qnARST   (qnARST),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.wbDatR   (wbDatR),
		.wbAck    (wbAck),
		.gpioBus  (gpioBus),
		.timerBus (timerBus)
	);

	gpioBlock gpioBlock
	(
		.iMCLK      (iMCLK),
		.qnARST     (qnARST),
		.bus        (gpioBus),
		.gpioIn     (gpioIn),
		.gpioOut    (gpioOut),
		.gpioOe     (gpioOe),
		.timerMatch (timerMatch),
		.timerBeat  (timerBeat)
	);

	sysTimerBlock sysTimerBlock
	(
		.iMCLK      (iMCLK),
		.qnARST     (qnARST),
		.bus        (timerBus),
		.timerMatch (timerMatch),
		.timerBeat  (timerBeat)
	);

endmodule

`default_nettype wire

/* dv/usiBusCtrl_sva.sv */
//------------------------------
// Wishbone handshake assertions for the bus controller
// Bound into every usiBusCtrl instance
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module usiBusCtrlSva
(
	input logic              iMCLK,
	input logic              qnARST,
	input logic              wbAck,
	input logic              accept,
	input logic              gpioWr,
	input logic              timerWr,
	input usiPkg::busState_t busState
);

	// Single cycle ack
	ackOnePulse: assert property (@(posedge iMCLK) disable iff (!qnARST)
		wbAck |=> !wbAck)
		else $error("wbAck held for more than one cycle");

	// Ack state entered only from the access cycle of an accepted strobe
	ackInAckState: assert property (@(posedge iMCLK) disable iff (!qnARST)
		wbAck |-> $past(busState == usiPkg::busAccess) && $past(accept, 2))
		else $error("wbAck without an accepted strobe and access cycle before it");

	// One target block per transfer, strobe only in the access cycle
	oneWriteStrobe: assert property (@(posedge iMCLK) disable iff (!qnARST)
		(gpioWr || timerWr) |->
			!(gpioWr && timerWr) && (busState == usiPkg::busAccess))
		else $error("write strobe on both blocks or outside the access cycle");

	// Fixed latency from accept to ack
	ackLatency: assert property (@(posedge iMCLK) disable iff (!qnARST)
		accept |-> ##2 wbAck)
		else $error("wbAck missing two edges after an accepted strobe");

endmodule

bind usiBusCtrl usiBusCtrlSva sva
(
	.iMCLK    (iMCLK),
	.qnARST   (qnARST),
	.wbAck    (wbAck),
	.accept   (accept),
	.gpioWr   (gpioWr),
	.timerWr  (timerWr),
	.busState (busState)
);

`default_nettype wire

/* dv/midiBoardTopTb.sv */
//------------------------------
// Testbench for the board peripheral top level
// Random Wishbone transfers and GPIO inputs checked
// against a register and pin model kept here
// Bus controller assertions are bound in a separate file
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module midiBoardTopTb;

	localparam int lpClkPeriod = 8;
	localparam int lpRstCycles = 5;
	localparam logic [31:0] lpSeed = 32'hd980e6d7;
	// Cycles to wait for wbAck before calling it a hang
	localparam int lpAckLimit = 16;
	localparam int lpGpioIters = 20;
	localparam int lpSyncIters = 8;
	localparam int lpAltIters = 6;
	localparam int lpUnmapIters = 6;
	// Transfers over all tests, about 3 cycles each
	localparam int lpTransfers = 8 + lpGpioIters * 4 + lpSyncIters + 8
		+ 5 + lpAltIters * 2 + lpUnmapIters * 7;
	// Reset, timer and synchronizer waits
	localparam int lpWaitCycles = lpRstCycles + 3 + 25 * 2 + lpSyncIters * 3;
	localparam int lpTimeoutCycles = lpTransfers * 3 * 4 + lpWaitCycles;

	logic iMCLK;
	logic qnARST;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	usiPkg::usiAdrs_t wbAdr;
	usiPkg::usiData_t wbDatW;
	usiPkg::usiData_t wbDatR;
	logic wbAck;
	usiPkg::gpio_t gpioIn;
	usiPkg::gpio_t gpioOut;
	usiPkg::gpio_t gpioOe;

	// Register model
	usiPkg::gpio_t expOut;
	usiPkg::gpio_t expDir;
	usiPkg::gpio_t expAlt;
	usiPkg::usiData_t expCmp;
	logic expEnable;

	int errCount;
	int testCount;
	int testsFailed;
	int testErrBase;

	midiBoardTop uut
	(
		.iMCLK  (iMCLK),
		.qnARST (qnARST),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbDatR (wbDatR),
		.wbAck  (wbAck),
		.gpioIn (gpioIn),
		.gpioOut(gpioOut),
		.gpioOe (gpioOe)
	);

	always #(lpClkPeriod / 2) iMCLK = ~iMCLK;

	//------------------------------
	// Helpers
	//------------------------------
	function automatic usiPkg::usiAdrs_t regAdr(input logic [3:0] blk,
		input usiPkg::usiRegIdx_t idx);
		return {blk, idx};
	endfunction

	// Expected pins: heartbeat on even pins, match on odd pins where ALT is set
	function automatic usiPkg::gpio_t pinModel(input usiPkg::gpio_t outV,
		input usiPkg::gpio_t altV, input logic match, input logic beat);
		usiPkg::gpio_t pins;
		for (int i = 0; i < 6; i++)
		begin
			if (altV[i])
				pins[i] = (i % 2 == 0) ? beat : match;
			else
				pins[i] = outV[i];
		end
		return pins;
	endfunction

	task automatic checkEq(input string name, input usiPkg::usiData_t expVal,
		input usiPkg::usiData_t actVal);
		if (expVal !== actVal)
		begin
			$display("** Error [%s] expected 0x%08h actual 0x%08h", name, expVal, actVal);
			errCount++;
		end
	endtask

	// Called on a falling edge, returns on the falling edge of the ack cycle
	task automatic busTransfer(input logic we, input usiPkg::usiAdrs_t adr,
		input usiPkg::usiData_t datW, output usiPkg::usiData_t datR);
		int waitCnt;
		waitCnt = 0;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = datW;
		@(negedge iMCLK);
		while (!wbAck && waitCnt < lpAckLimit)
		begin
			waitCnt++;
			@(negedge iMCLK);
		end
		datR = wbDatR;
		if (!wbAck)
		begin
			$display("Bus hang: no acknowledge for address 0x%02h within %0d cycles",
				adr, lpAckLimit);
			errCount++;
		end
		// Strobe drops before the edge that ends the ack cycle
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input usiPkg::usiAdrs_t adr, input usiPkg::usiData_t dat);
		usiPkg::usiData_t unused;
		busTransfer(1'b1, adr, dat, unused);
	endtask

	task automatic wbRead(input usiPkg::usiAdrs_t adr, output usiPkg::usiData_t dat);
		busTransfer(1'b0, adr, '0, dat);
	endtask

	task automatic startTest();
		testErrBase = errCount;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errCount != testErrBase)
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errCount - testErrBase);
		end
		else
			$display("test %s: ok", name);
	endtask

	// Reads one register and compares it with the model
	task automatic readCheck(input string name, input usiPkg::usiAdrs_t adr,
		input usiPkg::usiData_t expVal);
		usiPkg::usiData_t rd;
		wbRead(adr, rd);
		checkEq(name, expVal, rd);
	endtask

	//------------------------------
	// Watchdog
	//------------------------------
	initial
	begin
		#(lpTimeoutCycles * lpClkPeriod);
		$display("Watchdog expired after %0d cycles, run did not complete", lpTimeoutCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	//------------------------------
	// Test sequence
	//------------------------------
	initial
	begin
		usiPkg::usiData_t data;
		usiPkg::usiData_t rd;
		usiPkg::usiData_t rd2;
		int cmpVal;
		logic sMatch;
		logic sBeat;
		logic [3:0] blk;

		data = $urandom(lpSeed);
		iMCLK = 1'b0;
		qnARST = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		gpioIn = usiPkg::gpio_t'($urandom);
		errCount = 0;
		testCount = 0;
		testsFailed = 0;
		testErrBase = 0;
		expOut = '0;
		expDir = '0;
		expAlt = '0;
		expCmp = '0;
		expEnable = 1'b0;
		sMatch = 1'b0;
		sBeat = 1'b0;

		repeat (lpRstCycles) @(negedge iMCLK);
		qnARST = 1'b1;
		// Let the input synchronizer fill
		repeat (3) @(negedge iMCLK);

		// Reset state
		startTest();
		checkEq("reset gpioOut", 32'(0), 32'(gpioOut));
		checkEq("reset gpioOe", 32'(0), 32'(gpioOe));
		readCheck("reset OUT", regAdr(4'd0, 4'd0), 32'(0));
		readCheck("reset DIR", regAdr(4'd0, 4'd1), 32'(0));
		readCheck("reset ALT", regAdr(4'd0, 4'd2), 32'(0));
		readCheck("reset IN", regAdr(4'd0, 4'd3), 32'(gpioIn));
		readCheck("reset CTRL", regAdr(4'd1, 4'd0), 32'(0));
		readCheck("reset COUNT", regAdr(4'd1, 4'd1), 32'(0));
		readCheck("reset CMP", regAdr(4'd1, 4'd2), 32'(0));
		readCheck("reset STAT", regAdr(4'd1, 4'd3), 32'(0));
		finishTest("reset");

		// OUT and DIR readback, pins follow right after the ack
		startTest();
		for (int i = 0; i < lpGpioIters; i++)
		begin
			data = $urandom;
			wbWrite(regAdr(4'd0, 4'd0), data);
			expOut = data[5:0];
			checkEq("gpio pins out", 32'(expOut), 32'(gpioOut));
			data = $urandom;
			wbWrite(regAdr(4'd0, 4'd1), data);
			expDir = data[5:0];
			checkEq("gpio pins oe", 32'(expDir), 32'(gpioOe));
			readCheck("gpio OUT", regAdr(4'd0, 4'd0), 32'(expOut));
			readCheck("gpio DIR", regAdr(4'd0, 4'd1), 32'(expDir));
		end
		finishTest("gpio readback");

		// Input synchronizer, two edges of latency
		startTest();
		for (int i = 0; i < lpSyncIters; i++)
		begin
			gpioIn = usiPkg::gpio_t'($urandom);
			repeat (3) @(negedge iMCLK);
			readCheck("sync IN", regAdr(4'd0, 4'd3), 32'(gpioIn));
		end
		finishTest("input sync");

		// Timer wrap sets match, write 1 clears it
		startTest();
		cmpVal = 2 + int'($urandom % 19);
		wbWrite(regAdr(4'd1, 4'd2), 32'(cmpVal));
		expCmp = 32'(cmpVal);
		wbWrite(regAdr(4'd1, 4'd0), 32'd1);
		repeat (cmpVal + 5) @(negedge iMCLK);
		wbRead(regAdr(4'd1, 4'd3), rd);
		checkEq("timer match set", 32'd1, 32'(rd[0]));
		wbWrite(regAdr(4'd1, 4'd0), 32'd0);
		expEnable = 1'b0;
		wbWrite(regAdr(4'd1, 4'd3), 32'd1);
		wbRead(regAdr(4'd1, 4'd3), rd);
		checkEq("timer match clear", 32'd0, 32'(rd[0]));
		wbRead(regAdr(4'd1, 4'd1), rd);
		wbRead(regAdr(4'd1, 4'd1), rd2);
		checkEq("timer count frozen", rd, rd2);
		checkEq("timer count range", 32'd1, 32'(rd <= 32'(cmpVal)));
		finishTest("timer match");

		// Alternate function with the timer stopped
		startTest();
		// One more wrap so the match flag is set for the first half
		wbWrite(regAdr(4'd1, 4'd0), 32'd1);
		repeat (cmpVal + 5) @(negedge iMCLK);
		wbWrite(regAdr(4'd1, 4'd0), 32'd0);
		for (int i = 0; i < lpAltIters; i++)
		begin
			// Match flag cleared for the second half
			if (i == lpAltIters / 2)
				wbWrite(regAdr(4'd1, 4'd3), 32'd1);
			if (i == 0 || i == lpAltIters / 2)
			begin
				wbRead(regAdr(4'd1, 4'd3), rd);
				sMatch = rd[0];
				sBeat = rd[1];
				checkEq("alt match flag", 32'(i == 0), 32'(sMatch));
			end
			data = $urandom;
			wbWrite(regAdr(4'd0, 4'd0), data);
			expOut = data[5:0];
			data = $urandom;
			wbWrite(regAdr(4'd0, 4'd2), data);
			expAlt = data[5:0];
			checkEq("alt pins", 32'(pinModel(expOut, expAlt, sMatch, sBeat)),
				32'(gpioOut));
			checkEq("alt oe", 32'(expDir), 32'(gpioOe));
		end
		finishTest("alternate function");

		// Unmapped blocks ack, ignore writes and read zero
		startTest();
		for (int i = 0; i < lpUnmapIters; i++)
		begin
			blk = 4'(2 + ($urandom % 14));
			wbWrite(regAdr(blk, 4'($urandom)), $urandom);
			readCheck("unmapped read", regAdr(blk, 4'($urandom)), 32'(0));
			readCheck("unmapped OUT", regAdr(4'd0, 4'd0), 32'(expOut));
			readCheck("unmapped DIR", regAdr(4'd0, 4'd1), 32'(expDir));
			readCheck("unmapped ALT", regAdr(4'd0, 4'd2), 32'(expAlt));
			readCheck("unmapped CTRL", regAdr(4'd1, 4'd0), 32'(expEnable));
			readCheck("unmapped CMP", regAdr(4'd1, 4'd2), expCmp);
		end
		finishTest("unmapped blocks");

		$display("tests run %0d, tests failed %0d, errors %0d", testCount, testsFailed,
			errCount);
		if (errCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* midiBoardTop.f */
hdl/usiPkg.sv
hdl/usiBusIf.sv
hdl/usiBusCtrl.sv
hdl/gpioBlock.sv
hdl/sysTimerBlock.sv
hdl/midiBoardTop.sv
dv/usiBusCtrl_sva.sv
dv/midiBoardTopTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f midiBoardTop.f --top-module midiBoardTopTb -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VmidiBoardTopTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
